//--- faultUnit.sv
`timescale 1ns/1ps
`include "mmu_defines.svh"

module faultUnit (
  input  logic                clk,
  input  logic                reset,
  input  logic                check,
  input  mmuPkg::addrT        vAddr,
  input  logic                wordAccess,
  input  logic                cpuWrite,
  input  logic                supMode,
  input  logic                dataAccess,
  input  logic [31:0]         domainAccess,
  input  mmuPkg::translationT translation,
  input  logic                walkFault,
  output logic                faultValid,
  output logic                fetchFault,
  output logic                dataAbort,
  output logic                mmuWriteEn,
  output logic [3:0]          cp15A,
  output logic [31:0]         mmuWriteData
);
  import mmuPkg::*;

  typedef enum logic [1:0] {recIdle, recFsr, recFar} recStateT;

  recStateT  recState;
  logic      alignFault;
  logic      domainFault;
  logic      permFault;
  logic      apDenied;
  logic [1:0] domainMode;
  faultCodeT faultCode;
  domainT    faultDomain;
  faultCodeT codeQ;
  domainT    domainQ;
  addrT      farQ;

  assign alignFault = wordAccess && (vAddr[1:0] != 2'b00);

  // Two bits per domain, 00 and reserved 10 deny
  assign domainMode  = domainAccess[{translation.domain, 1'b0} +: 2];
  assign domainFault = translation.hit && !domainMode[0];

  // AP check for client domains only
  always_comb begin
    case (translation.ap)
      2'b00:   apDenied = 1'b1;
      2'b01:   apDenied = !supMode;
      2'b10:   apDenied = !supMode && cpuWrite;
      default: apDenied = 1'b0;
    endcase
  end
  assign permFault = translation.hit && (domainMode == 2'b01) && apDenied;

  // Alignment first, then translation, domain and permission
  always_comb begin
    faultDomain = translation.domain;
    if (alignFault) begin
      faultCode   = faultAlignment;
      faultDomain = '0;
    end else if (walkFault) begin
      faultCode = translation.isSection ? faultSectionTranslation : faultPageTranslation;
    end else if (domainFault) begin
      faultCode = translation.isSection ? faultSectionDomain : faultPageDomain;
    end else begin
      faultCode = translation.isSection ? faultSectionPermission : faultPagePermission;
    end
  end

  assign faultValid = check && (alignFault || walkFault || domainFault || permFault);
  assign dataAbort  = faultValid && dataAccess;
  // Fetch faults are deferred to the tracker
  assign fetchFault = faultValid && !dataAccess;

  // FSR then FAR, one cycle each
  always_ff @(posedge clk) begin
    if (reset) begin
      recState <= recIdle;
    end else begin
      case (recState)
        recIdle: begin
          if (faultValid) begin
            recState <= recFsr;
          end
        end
        recFsr:  recState <= recFar;
        default: recState <= recIdle;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (faultValid) begin
      codeQ   <= faultCode;
      domainQ <= faultDomain;
      farQ    <= vAddr;
    end
  end

  assign mmuWriteEn   = (recState != recIdle);
  assign cp15A        = (recState == recFar) ? 4'(`MMU_CP15_FAR) : 4'(`MMU_CP15_FSR);
  assign mmuWriteData = (recState == recFar) ? farQ : {24'b0, domainQ, codeQ};

  // Top holds new requests off while a record is written
  assert property (@(posedge clk) disable iff (reset) faultValid |-> !mmuWriteEn)
    else $error("faultUnit: new fault while a CP15 record is written");

endmodule

//--- instrTracker.sv
`timescale 1ns/1ps

module instrTracker (
  input  logic clk,
  input  logic reset,
  input  logic fetchFault,
  input  logic stallD,
  input  logic flushD,
  input  logic flushE,
  output logic prefetchAbort
);

  // Faulting instruction pending in decode
  logic pendD;
  // Faulting instruction now in execute
  logic pendE;

  always_ff @(posedge clk) begin
    if (reset) begin
      pendD         <= 1'b0;
      pendE         <= 1'b0;
      prefetchAbort <= 1'b0;
    end else begin
      // Flush kills it, otherwise it leaves decode once unstalled
      if (flushD) begin
        pendD <= 1'b0;
      end else if (fetchFault) begin
        pendD <= 1'b1;
      end else if (!stallD) begin
        pendD <= 1'b0;
      end
      // Moves to execute on first unstalled cycle
      pendE <= pendD && !stallD && !flushD && !flushE;
      // Abort only if execute was not flushed
      prefetchAbort <= pendE && !flushE;
    end
  end

endmodule

//--- mmu.sv
`timescale 1ns/1ps

module mmu (
  input  logic         clk,
  input  logic         reset,
  input  logic         cpuRequest,
  input  logic         cpuWrite,
  input  mmuPkg::addrT cpuAddr,
  input  logic         dataAccess,
  input  logic         wordAccess,
  input  logic         supMode,
  input  logic [31:0]  control,
  input  logic [17:0]  tBase,
  input  logic [31:0]  domainAccess,
  input  logic         tlbInvalidate,
  input  logic         hReady,
  input  logic [31:0]  hRData,
  input  logic         stallD,
  input  logic         flushD,
  input  logic         flushE,
  output mmuPkg::addrT hAddr,
  output logic         hRequest,
  output logic         hWrite,
  output logic         cpuReady,
  output logic         mmuWriteEn,
  output logic [3:0]   cp15A,
  output logic [31:0]  mmuWriteData,
  output logic         dataAbort,
  output logic         prefetchAbort
);
  import mmuPkg::*;

  // Access sequencer: lookup, check/access, walk
  typedef enum logic [1:0] {accIdle, accCheck, accWalk} accStateT;

  accStateT    accState;
  logic        enable;
  logic        dataReq;
  logic        walkStart;
  logic        check;
  logic        faultValid;
  logic        fetchFault;
  logic        walkRequest;
  logic        refill;
  logic        walkFault;
  logic        walkDone;
  addrT        walkAddr;
  addrT        physAddr;
  translationT tlbResult;
  translationT walkResult;
  translationT checked;

  assign enable = control[0];

  // New request waits out a pending fault record
  always_ff @(posedge clk) begin
    if (reset) begin
      accState <= accIdle;
    end else begin
      case (accState)
        accIdle: begin
          if (enable && cpuRequest && !mmuWriteEn) begin
            accState <= accCheck;
          end
        end
        accCheck: begin
          if (faultValid) begin
            accState <= accIdle;
          end else if (!tlbResult.hit) begin
            accState <= accWalk;
          end else if (hReady) begin
            accState <= accIdle;
          end
        end
        accWalk: begin
          if (walkDone) begin
            // Refilled entry hits on the next check
            accState <= walkFault ? accIdle : accCheck;
          end
        end
        default: accState <= accIdle;
      endcase
    end
  end

  // Check on every lookup and on a failed walk
  assign check     = (accState == accCheck) || ((accState == accWalk) && walkFault);
  assign checked   = (accState == accWalk) ? walkResult : tlbResult;
  assign dataReq   = (accState == accCheck) && tlbResult.hit && !faultValid;
  assign walkStart = (accState == accCheck) && !tlbResult.hit && !faultValid;
  assign physAddr  = {tlbResult.physTag, cpuAddr[11:0]};

  // Bus mux: bypass, walker, translated data access
  always_comb begin
    if (!enable) begin
      hAddr    = cpuAddr;
      hRequest = cpuRequest;
      hWrite   = cpuWrite;
      cpuReady = hReady;
    end else if (walkRequest) begin
      hAddr    = walkAddr;
      hRequest = 1'b1;
      hWrite   = 1'b0;
      cpuReady = 1'b0;
    end else begin
      hAddr    = physAddr;
      hRequest = dataReq;
      hWrite   = dataReq && cpuWrite;
      cpuReady = (dataReq && hReady) || faultValid;
    end
  end

  tlb tlb0 (
    .clk           (clk),
    .reset         (reset),
    .tlbInvalidate (tlbInvalidate),
    .lookupTag     (cpuAddr[31:12]),
    .refill        (refill),
    .refillTag     (cpuAddr[31:12]),
    .refillData    (walkResult),
    .result        (tlbResult)
  );

  tableWalker walker0 (
    .clk         (clk),
    .reset       (reset),
    .start       (walkStart),
    .vAddr       (cpuAddr),
    .tBase       (tBase),
    .hRData      (hRData),
    .hReady      (hReady),
    .walkAddr    (walkAddr),
    .walkRequest (walkRequest),
    .refill      (refill),
    .walkResult  (walkResult),
    .walkFault   (walkFault),
    .walkDone    (walkDone)
  );

  faultUnit fault0 (
    .clk          (clk),
    .reset        (reset),
    .check        (check),
    .vAddr        (cpuAddr),
    .wordAccess   (wordAccess),
    .cpuWrite     (cpuWrite),
    .supMode      (supMode),
    .dataAccess   (dataAccess),
    .domainAccess (domainAccess),
    .translation  (checked),
    .walkFault    (walkFault),
    .faultValid   (faultValid),
    .fetchFault   (fetchFault),
    .dataAbort    (dataAbort),
    .mmuWriteEn   (mmuWriteEn),
    .cp15A        (cp15A),
    .mmuWriteData (mmuWriteData)
  );

  instrTracker tracker0 (
    .clk           (clk),
    .reset         (reset),
    .fetchFault    (fetchFault),
    .stallD        (stallD),
    .flushD        (flushD),
    .flushE        (flushE),
    .prefetchAbort (prefetchAbort)
  );

endmodule

//--- mmuPkg.sv
package mmuPkg;

  // Virtual or physical byte address
  typedef logic [31:0] addrT;
  // Page number, 4 KB granularity
  typedef logic [19:0] tagT;
  typedef logic [3:0]  domainT;
  // Access permission bits from the descriptor
  typedef logic [1:0]  apT;
  // FSR status code
  typedef logic [3:0]  faultCodeT;

  // Table walker states
  typedef enum logic [1:0] {
    wsIdle,
    wsLevel1,
    wsLevel2,
    wsDone
  } walkStateT;

  // One TLB entry, sections stored as 256 small pages
  typedef struct packed {
    logic   valid;
    logic   isSection;
    tagT    virtTag;
    tagT    physTag;
    domainT domain;
    apT     ap;
  } tlbEntryT;

  // Translation result from TLB lookup or table walk
  typedef struct packed {
    logic   hit;
    logic   isSection;
    tagT    physTag;
    domainT domain;
    apT     ap;
  } translationT;

  // Fault status codes, section and page variants
  localparam faultCodeT faultAlignment          = 4'b0001;
  localparam faultCodeT faultSectionTranslation = 4'b0101;
  localparam faultCodeT faultPageTranslation    = 4'b0111;
  localparam faultCodeT faultSectionDomain      = 4'b1001;
  localparam faultCodeT faultPageDomain         = 4'b1011;
  localparam faultCodeT faultSectionPermission  = 4'b1101;
  localparam faultCodeT faultPagePermission     = 4'b1111;

endpackage

//--- mmuTb.sv
`timescale 1ns/1ps

module mmuTb;

  // One stimulus row with its expected results
  typedef struct packed {
    logic [1:0]  ctl;       // enable, invalidate TLB first
    logic [31:0] addr;
    logic [3:0]  mode;      // write, dataAccess, wordAccess, supMode
    logic [31:0] dacr;
    logic [3:0]  pipe;      // decode stalls (2 bits), flushD, flushE
    logic [2:0]  expFlags;  // fault, dataAbort, prefetchAbort
    logic [31:0] expValue;  // bus address, or FSR data on a fault
    logic [1:0]  expReads;
  } rowT;

  localparam int numRows      = 20;
  localparam int timeoutLimit = numRows * 64;
  // Domain access words, two bits per domain
  localparam logic [31:0] dacrCli  = 32'h5555_5555;
  localparam logic [31:0] dacrNo2  = 32'h5555_5545;
  localparam logic [31:0] dacrMgr3 = 32'h5555_55d5;
  localparam logic [3:0]  fsrReg   = 4'd5;
  localparam logic [3:0]  farReg   = 4'd6;

  logic        clk;
  logic        reset;
  logic        cpuRequest;
  logic        cpuWrite;
  logic [31:0] cpuAddr;
  logic        dataAccess;
  logic        wordAccess;
  logic        supMode;
  logic [31:0] control;
  logic [17:0] tBase;
  logic [31:0] domainAccess;
  logic        tlbInvalidate;
  logic        hReady;
  logic [31:0] hRData;
  logic        stallD;
  logic        flushD;
  logic        flushE;
  logic [31:0] hAddr;
  logic        hRequest;
  logic        hWrite;
  logic        cpuReady;
  logic        mmuWriteEn;
  logic [3:0]  cp15A;
  logic [31:0] mmuWriteData;
  logic        dataAbort;
  logic        prefetchAbort;

  // Low 64 KB of physical memory, page tables only
  logic [31:0] mem [16384];
  rowT         rows [numRows];
  logic [35:0] cpWrites [$];
  int          descReads;
  int          prefetchCount;
  int          cycleCount;

  mmu dut0 (.*);

  always #20 clk = ~clk;

  // Random bus wait states from a seeded stream
  initial begin
    hReady = 1'b0;
    void'($urandom(32'h1195_98c1));
    forever begin
      @(posedge clk);
      #2;
      hReady = ($urandom % 4) != 0;
    end
  end

  // Tables below 64 KB and the inverted address above
  always_comb begin
    if (hAddr < 32'h0001_0000) begin
      hRData = mem[hAddr[15:2]];
    end else begin
      hRData = ~hAddr;
    end
  end

  // Bus and abort monitor sampled mid-cycle where all is settled
  always @(negedge clk) begin
    if (!reset) begin
      if (hRequest && hReady && !hWrite && (hAddr < 32'h0001_0000)) begin
        descReads++;
      end
      if (mmuWriteEn) begin
        cpWrites.push_back({cp15A, mmuWriteData});
      end
      if (prefetchAbort) begin
        prefetchCount++;
      end
    end
  end

  always @(posedge clk) begin
    cycleCount++;
    if (cycleCount > timeoutLimit) begin
      reportProblem($sformatf("run exceeded %0d cycles without finishing", timeoutLimit));
    end
  end

  task automatic stopRun();
    $display("Testbench failed");
    $fatal(1, "stopping at the first error");
  endtask

  task automatic reportProblem(input string msg);
    $display("%s", msg);
    stopRun();
  endtask

  task automatic reportMismatch(input int idx, input string name, input logic [35:0] got,
                                input logic [35:0] exp);
    $display("FAIL %s row %0d: got %h expected %h", name, idx, got, exp);
    stopRun();
  endtask

  // First-level section: base, AP in 11..10, domain in 8..5
  function automatic logic [31:0] sectionDesc(input logic [11:0] base, input logic [1:0] ap,
                                              input logic [3:0] dom);
    return {base, 8'h00, ap, 1'b0, dom, 3'b000, 2'b10};
  endfunction

  // First-level coarse pointer, 1 KB aligned table
  function automatic logic [31:0] coarseDesc(input logic [21:0] base, input logic [3:0] dom);
    return {base, 1'b0, dom, 3'b000, 2'b01};
  endfunction

  // Second-level small page, AP in 5..4
  function automatic logic [31:0] smallDesc(input logic [19:0] page, input logic [1:0] ap);
    return {page, 6'b000000, ap, 2'b00, 2'b10};
  endfunction

  task automatic loadMemory();
    // Unused words hold their own byte address and decode as fault descriptors
    for (int i = 0; i < 16384; i++) begin
      mem[i] = 32'(i) << 2;
    end
    // L1 table at 0x4000, L2 coarse table at 0x8000
    mem[14'h1001] = sectionDesc(12'h123, 2'b11, 4'd0);
    mem[14'h1002] = coarseDesc(22'h20, 4'd1);
    mem[14'h1004] = sectionDesc(12'h456, 2'b11, 4'd2);
    mem[14'h1005] = sectionDesc(12'h789, 2'b10, 4'd3);
    mem[14'h2005] = smallDesc(20'h00abc, 2'b11);
    mem[14'h2006] = smallDesc(20'h00abd, 2'b01);
  endtask

  task automatic loadRows();
    // Bypass
    rows[0]  = '{2'b00, 32'h0003_0040, 4'b0111, dacrCli, 4'h0, 3'b000, 32'h0003_0040, 2'd0};
    rows[1]  = '{2'b00, 32'h1234_5678, 4'b1100, dacrCli, 4'h0, 3'b000, 32'h1234_5678, 2'd0};
    // Section walk, TLB hit, page in same section, small page walk and hit
    rows[2]  = '{2'b10, 32'h0012_3454, 4'b0111, dacrCli, 4'h0, 3'b000, 32'h1232_3454, 2'd1};
    rows[3]  = '{2'b10, 32'h0012_3454, 4'b0111, dacrCli, 4'h0, 3'b000, 32'h1232_3454, 2'd0};
    rows[4]  = '{2'b10, 32'h0012_4008, 4'b0110, dacrCli, 4'h0, 3'b000, 32'h1232_4008, 2'd1};
    rows[5]  = '{2'b10, 32'h0020_5678, 4'b0100, dacrCli, 4'h0, 3'b000, 32'h00ab_c678, 2'd2};
    rows[6]  = '{2'b10, 32'h0020_567c, 4'b1110, dacrCli, 4'h0, 3'b000, 32'h00ab_c67c, 2'd0};
    // Invalidate forces a new walk
    rows[7]  = '{2'b11, 32'h0012_3454, 4'b0111, dacrCli, 4'h0, 3'b000, 32'h1232_3454, 2'd1};
    // Data aborts with FSR data in the value column
    rows[8]  = '{2'b10, 32'h0012_3456, 4'b0111, dacrCli, 4'h0, 3'b110, 32'h0000_0001, 2'd0};
    rows[9]  = '{2'b10, 32'h0030_0000, 4'b0100, dacrCli, 4'h0, 3'b110, 32'h0000_0005, 2'd1};
    rows[10] = '{2'b10, 32'h0020_7000, 4'b0100, dacrCli, 4'h0, 3'b110, 32'h0000_0017, 2'd2};
    rows[11] = '{2'b10, 32'h0040_0010, 4'b0100, dacrNo2, 4'h0, 3'b110, 32'h0000_0029, 2'd1};
    rows[12] = '{2'b10, 32'h0020_6010, 4'b0100, dacrCli, 4'h0, 3'b110, 32'h0000_001f, 2'd2};
    rows[13] = '{2'b10, 32'h0050_0020, 4'b1100, dacrCli, 4'h0, 3'b110, 32'h0000_003d, 2'd1};
    // Manager skips AP, supervisor may use a supervisor-only page
    rows[14] = '{2'b10, 32'h0050_0020, 4'b1100, dacrMgr3, 4'h0, 3'b000, 32'h7890_0020, 2'd0};
    rows[15] = '{2'b10, 32'h0020_6014, 4'b0111, dacrCli, 4'h0, 3'b000, 32'h00ab_d014, 2'd0};
    // Fetch faults, then stall or flush in decode and execute
    rows[16] = '{2'b10, 32'h0030_0004, 4'b0011, dacrCli, 4'h8, 3'b101, 32'h0000_0005, 2'd1};
    rows[17] = '{2'b10, 32'h0030_0004, 4'b0011, dacrCli, 4'h6, 3'b100, 32'h0000_0005, 2'd1};
    rows[18] = '{2'b10, 32'h0030_0004, 4'b0011, dacrCli, 4'h1, 3'b100, 32'h0000_0005, 2'd1};
    rows[19] = '{2'b10, 32'h0012_3000, 4'b0011, dacrCli, 4'h0, 3'b000, 32'h1232_3000, 2'd0};
  endtask

  task automatic applyRow(input int idx, input rowT r);
    int          readsBefore;
    int          writesBefore;
    int          abortsBefore;
    int          nWrites;
    logic [31:0] addrSeen;
    logic        reqSeen;
    logic        writeSeen;
    logic        abortSeen;
    logic        fault;
    fault        = r.expFlags[2];
    control      = {31'b0, r.ctl[1]};
    domainAccess = r.dacr;
    if (r.ctl[0]) begin
      tlbInvalidate = 1'b1;
      @(posedge clk);
      #2;
      tlbInvalidate = 1'b0;
    end
    readsBefore  = descReads;
    writesBefore = cpWrites.size();
    abortsBefore = prefetchCount;
    cpuAddr      = r.addr;
    {cpuWrite, dataAccess, wordAccess, supMode} = r.mode;
    cpuRequest   = 1'b1;
    // Access ends on the edge after cpuReady is seen
    @(negedge clk);
    while (!cpuReady) begin
      @(negedge clk);
    end
    addrSeen  = hAddr;
    reqSeen   = hRequest;
    writeSeen = hWrite;
    abortSeen = dataAbort;
    @(posedge clk);
    #2;
    cpuRequest = 1'b0;
    // Decode stalls, then a cycle with flushD, then one with flushE
    stallD = 1'b1;
    repeat (r.pipe[3:2]) begin
      @(posedge clk);
      #2;
    end
    stallD = 1'b0;
    flushD = r.pipe[1];
    @(posedge clk);
    #2;
    flushD = 1'b0;
    flushE = r.pipe[0];
    @(posedge clk);
    #2;
    flushE = 1'b0;
    repeat (3) begin
      @(posedge clk);
    end
    #2;
    // No bus data access on a fault
    assert (reqSeen == !fault) else reportMismatch(idx, "hRequest", 36'(reqSeen), 36'(!fault));
    if (!fault) begin
      assert (addrSeen == r.expValue)
        else reportMismatch(idx, "hAddr", 36'(addrSeen), 36'(r.expValue));
      assert (writeSeen == r.mode[3])
        else reportMismatch(idx, "hWrite", 36'(writeSeen), 36'(r.mode[3]));
    end
    assert (abortSeen == r.expFlags[1])
      else reportMismatch(idx, "dataAbort", 36'(abortSeen), 36'(r.expFlags[1]));
    assert ((descReads - readsBefore) == int'(r.expReads))
      else reportMismatch(idx, "descriptor reads", 36'(descReads - readsBefore),
                          36'(r.expReads));
    assert ((prefetchCount - abortsBefore) == int'(r.expFlags[0]))
      else reportMismatch(idx, "prefetchAbort pulses", 36'(prefetchCount - abortsBefore),
                          36'(r.expFlags[0]));
    nWrites = cpWrites.size() - writesBefore;
    if (fault) begin
      assert (nWrites == 2)
        else reportProblem($sformatf("row %0d made %0d CP15 writes, two expected", idx, nWrites));
      // FSR first, then FAR with the virtual address
      assert (cpWrites[writesBefore] == {fsrReg, r.expValue})
        else reportMismatch(idx, "cp15A,mmuWriteData", cpWrites[writesBefore],
                            {fsrReg, r.expValue});
      assert (cpWrites[writesBefore + 1] == {farReg, r.addr})
        else reportMismatch(idx, "cp15A,mmuWriteData", cpWrites[writesBefore + 1],
                            {farReg, r.addr});
    end else begin
      assert (nWrites == 0)
        else reportProblem($sformatf("row %0d wrote CP15 without a fault", idx));
    end
  endtask

  initial begin
    clk           = 1'b0;
    reset         = 1'b1;
    cpuRequest    = 1'b0;
    cpuWrite      = 1'b0;
    cpuAddr       = 32'h0;
    dataAccess    = 1'b0;
    wordAccess    = 1'b0;
    supMode       = 1'b0;
    control       = 32'h0;
    tBase         = 18'h0_0001;
    domainAccess  = dacrCli;
    tlbInvalidate = 1'b0;
    stallD        = 1'b0;
    flushD        = 1'b0;
    flushE        = 1'b0;
    descReads     = 0;
    prefetchCount = 0;
    cycleCount    = 0;
    loadMemory();
    loadRows();
    repeat (3) begin
      @(posedge clk);
    end
    #2;
    reset = 1'b0;
    for (int i = 0; i < numRows; i++) begin
      applyRow(i, rows[i]);
    end
    $display("Testbench passed");
    $finish;
  end

endmodule

//--- mmu_defines.svh
`ifndef MMU_DEFINES_SVH
`define MMU_DEFINES_SVH

// Number of fully associative TLB entries
// Round-robin refill pointer wraps at this count
`define MMU_TLB_ENTRIES 16

// CP15 register numbers used for the fault record
// Fault status register, domain and code
`define MMU_CP15_FSR 5

// Fault address register, faulting virtual address
`define MMU_CP15_FAR 6

`endif

//--- runSim.sh
#!/usr/bin/env bash
# Build the MMU testbench with Verilator, run it and look for the pass line
cd "$(dirname "$0")" || exit 1

verilator --binary --assert -Wno-fatal -f src.f --top-module mmuTb -o mmuSim \
  || { echo "Build failed"; exit 1; }

simOut="$(./obj_dir/mmuSim 2>&1)"
echo "$simOut"

echo "$simOut" | grep -q "^Testbench passed$" && exit 0 || exit 1

//--- src.f
+incdir+.
mmuPkg.sv
tlb.sv
tableWalker.sv
faultUnit.sv
instrTracker.sv
mmu.sv
mmuTb.sv

//--- tableWalker.sv
`timescale 1ns/1ps

module tableWalker (
  input  logic                clk,
  input  logic                reset,
  input  logic                start,
  input  mmuPkg::addrT        vAddr,
  input  logic [17:0]         tBase,
  input  logic [31:0]         hRData,
  input  logic                hReady,
  output mmuPkg::addrT        walkAddr,
  output logic                walkRequest,
  output logic                refill,
  output mmuPkg::translationT walkResult,
  output logic                walkFault,
  output logic                walkDone
);
  import mmuPkg::*;

  // Descriptor type encodings, bits 1..0
  localparam logic [1:0] descSection   = 2'b10;
  localparam logic [1:0] descCoarse    = 2'b01;
  localparam logic [1:0] descSmallPage = 2'b10;

  walkStateT   state;
  translationT resultQ;
  logic        faultQ;
  // Coarse table base from first-level descriptor
  logic [21:0] coarseBase;

  always_ff @(posedge clk) begin
    if (reset) begin
      state  <= wsIdle;
      faultQ <= 1'b0;
    end else begin
      case (state)
        wsIdle: begin
          if (start) begin
            state <= wsLevel1;
          end
        end
        // First-level fetch, wait for bus
        wsLevel1: begin
          if (hReady) begin
            resultQ.domain    <= hRData[8:5];
            resultQ.isSection <= 1'b1;
            case (hRData[1:0])
              descSection: begin
                resultQ.hit     <= 1'b1;
                resultQ.physTag <= {hRData[31:20], vAddr[19:12]};
                resultQ.ap      <= hRData[11:10];
                faultQ          <= 1'b0;
                state           <= wsDone;
              end
              descCoarse: begin
                coarseBase <= hRData[31:10];
                state      <= wsLevel2;
              end
              default: begin
                // Fault and unsupported types, no valid domain
                resultQ.hit    <= 1'b0;
                resultQ.domain <= '0;
                faultQ         <= 1'b1;
                state          <= wsDone;
              end
            endcase
          end
        end
        // Second-level fetch, domain kept from level 1
        wsLevel2: begin
          if (hReady) begin
            resultQ.isSection <= 1'b0;
            if (hRData[1:0] == descSmallPage) begin
              resultQ.hit     <= 1'b1;
              resultQ.physTag <= hRData[31:12];
              resultQ.ap      <= hRData[5:4];
              faultQ          <= 1'b0;
            end else begin
              // Large and tiny pages end up here too
              resultQ.hit <= 1'b0;
              faultQ      <= 1'b1;
            end
            state <= wsDone;
          end
        end
        default: begin
          state <= wsIdle;
        end
      endcase
    end
  end

  // Descriptor address per level
  always_comb begin
    walkRequest = (state == wsLevel1) || (state == wsLevel2);
    if (state == wsLevel2) begin
      walkAddr = {coarseBase, vAddr[19:12], 2'b00};
    end else begin
      walkAddr = {tBase, vAddr[31:20], 2'b00};
    end
  end

  // Done lasts one cycle, refill or fault
  assign walkDone   = (state == wsDone);
  assign walkFault  = walkDone && faultQ;
  assign refill     = walkDone && !faultQ;
  assign walkResult = resultQ;

  // Bus request and address stay put through wait states
  assert property (@(posedge clk) disable iff (reset)
                   walkRequest && !hReady |=> walkRequest && $stable(walkAddr))
    else $error("tableWalker: request dropped before hReady");

endmodule

//--- tlb.sv
`timescale 1ns/1ps
`include "mmu_defines.svh"

module tlb (
  input  logic                clk,
  input  logic                reset,
  input  logic                tlbInvalidate,
  input  mmuPkg::tagT         lookupTag,
  input  logic                refill,
  input  mmuPkg::tagT         refillTag,
  input  mmuPkg::translationT refillData,
  output mmuPkg::translationT result
);
  import mmuPkg::*;

  localparam int idxWidth = $clog2(`MMU_TLB_ENTRIES);

  tlbEntryT                    entries [`MMU_TLB_ENTRIES];
  tagT                         tagQ;
  logic [idxWidth-1:0]         fillPtr;
  logic [`MMU_TLB_ENTRIES-1:0] matchVec;

  // Lookup tag captured every cycle
  always_ff @(posedge clk) begin
    tagQ <= lookupTag;
  end

  // Only valid bits see reset and invalidate
  always_ff @(posedge clk) begin
    if (reset || tlbInvalidate) begin
      for (int i = 0; i < `MMU_TLB_ENTRIES; i++) begin
        entries[i].valid <= 1'b0;
      end
    end else if (refill) begin
      entries[fillPtr] <= '{valid:     1'b1,
                            isSection: refillData.isSection,
                            virtTag:   refillTag,
                            physTag:   refillData.physTag,
                            domain:    refillData.domain,
                            ap:        refillData.ap};
    end
  end

  // Round-robin victim pointer
  always_ff @(posedge clk) begin
    if (reset) begin
      fillPtr <= '0;
    end else if (refill) begin
      if (fillPtr == idxWidth'(`MMU_TLB_ENTRIES - 1)) begin
        fillPtr <= '0;
      end else begin
        fillPtr <= fillPtr + 1'b1;
      end
    end
  end

  // Parallel compare against registered tag
  always_comb begin
    result = '0;
    for (int i = 0; i < `MMU_TLB_ENTRIES; i++) begin
      matchVec[i] = entries[i].valid && (entries[i].virtTag == tagQ);
      if (matchVec[i]) begin
        result.hit       = 1'b1;
        result.isSection = entries[i].isSection;
        result.physTag   = entries[i].physTag;
        result.domain    = entries[i].domain;
        result.ap        = entries[i].ap;
      end
    end
  end

  // Walker refills only on a miss, so a tag lives in one entry at most
  assert property (@(posedge clk) disable iff (reset) $onehot0(matchVec))
    else $error("tlb: several entries hold tag %h", tagQ);

  // Sequencer never refills while software invalidates
  assert property (@(posedge clk) disable iff (reset) !(refill && tlbInvalidate))
    else $error("tlb: refill during invalidate");

endmodule
